// File: build.f
+incdir+.
pe_pkg.sv
pe_scratchpad.sv
ifmap_loader.sv
filter_loader.sv
window_sequencer.sv
mac_pipeline.sv
conv_pe.sv
tb_conv_pe.sv

// File: Makefile
SIM := obj_dir/Vtb_conv_pe
SRCS := pe_pkg.sv pe_scratchpad.sv ifmap_loader.sv filter_loader.sv \
        window_sequencer.sv mac_pipeline.sv conv_pe.sv tb_conv_pe.sv \
        tb_conv_pe_cases.svh build.f

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS)
	verilator --binary -j 0 --assert -Wno-fatal --top-module tb_conv_pe -f build.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_conv_pe_cases.svh
`ifndef TB_CONV_PE_CASES_SVH
`define TB_CONV_PE_CASES_SVH

// Columns: row_len filt_len stride load_row max_data exp_windows
// exp_windows is the window count for that row, filter and stride
typedef struct packed {
    logic [5:0] row_len;
    logic [3:0] filt_len;
    logic [4:0] stride;
    logic       load_row;    // 0 keeps the stored row and reloads only the filter
    logic       max_data;    // every byte 8'hff instead of LFSR bytes
    logic [5:0] exp_windows;
} case_t;

localparam int NUM_CASES = 10;

localparam case_t [0:NUM_CASES-1] CASE_TABLE = '{
    '{6'd20, 4'd4, 5'd1, 1'b1, 1'b0, 6'd17},
    '{6'd20, 4'd3, 5'd2, 1'b0, 1'b0, 6'd9},
    '{6'd23, 4'd4, 5'd3, 1'b1, 1'b0, 6'd7},
    '{6'd23, 4'd5, 5'd2, 1'b0, 1'b0, 6'd10},
    '{6'd10, 4'd1, 5'd1, 1'b1, 1'b0, 6'd10},
    '{6'd10, 4'd1, 5'd3, 1'b0, 1'b0, 6'd4},
    '{6'd32, 4'd8, 5'd1, 1'b1, 1'b1, 6'd25},
    '{6'd32, 4'd8, 5'd5, 1'b0, 1'b1, 6'd5},
    '{6'd6,  4'd8, 5'd1, 1'b1, 1'b0, 6'd0},
    '{6'd7,  4'd7, 5'd2, 1'b1, 1'b0, 6'd1}
};

`endif

// File: tb_conv_pe.sv
`timescale 1ns/10ps

module tb_conv_pe;

    `include "tb_conv_pe_cases.svh"

    typedef logic [pe_pkg::ACC_W-1:0] acc_t;

    localparam int RUN_LIMIT  = 400;
    localparam int IDLE_LIMIT = 40;

    logic                 clk;
    logic                 reset;
    logic                 ifmap_valid;
    pe_pkg::ifmap_word_t  ifmap_in;
    logic                 cfg_valid;
    pe_pkg::conv_cfg_t    cfg_in;
    logic                 filt_valid;
    pe_pkg::filt_word_t   filt_in;
    logic                 start;
    logic                 result_valid;
    acc_t                 result;
    logic                 done;

    logic [31:0]          lfsr;
    logic [7:0]           row_mem [pe_pkg::IF_DEPTH];
    logic [7:0]           filt_mem [pe_pkg::FILT_DEPTH];
    acc_t                 got [$];
    acc_t                 expected [$];
    int                   row_len;
    int                   errors;
    int                   failed_tests;
    int                   checks;

    conv_pe i_conv_pe (
        .clk(clk), .reset(reset), .ifmap_valid(ifmap_valid), .ifmap_in(ifmap_in),
        .cfg_valid(cfg_valid), .cfg_in(cfg_in), .filt_valid(filt_valid),
        .filt_in(filt_in), .start(start), .result_valid(result_valid),
        .result(result), .done(done)
    );

    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_byte(input logic max_data, output logic [7:0] b);
        int i;
        b = 8'hff;
        if (!max_data) begin
            for (i = 0; i < 8; i++) begin
                lfsr = lfsr_step(lfsr);
                b = {b[6:0], lfsr[31]};
            end
        end
    endtask

    // Inputs change 2 ns after the edge, outputs are read there too
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic load_row(input int len, input logic max_data);
        logic [7:0] b;
        int i;
        for (i = 0; i < len; i++) begin
            next_byte(max_data, b);
            row_mem[i] = b;
            ifmap_valid = 1'b1;
            ifmap_in.last = (i == len - 1);
            ifmap_in.data = b;
            step();
        end
        ifmap_valid = 1'b0;
        row_len = len;
    endtask

    task automatic load_filter(input int flen, input int stride, input logic max_data);
        logic [7:0] b;
        int i;
        cfg_valid = 1'b1;
        cfg_in.filt_len = pe_pkg::filt_len_t'(flen);
        cfg_in.stride = 5'(stride);
        step();
        cfg_valid = 1'b0;
        for (i = 0; i < flen; i++) begin
            next_byte(max_data, b);
            filt_mem[i] = b;
            filt_valid = 1'b1;
            filt_in.data = b;
            step();
        end
        filt_valid = 1'b0;
        step();
    endtask

    // Sum over taps of feature[w * stride + t] * filter[t]
    task automatic build_expected(input int flen, input int stride);
        acc_t sum;
        int w;
        int t;
        expected.delete();
        w = 0;
        while (w * stride + flen <= row_len) begin
            sum = '0;
            for (t = 0; t < flen; t++) begin
                sum = sum + acc_t'(row_mem[w * stride + t]) * acc_t'(filt_mem[t]);
            end
            expected.push_back(sum);
            w++;
        end
    endtask

    task automatic run_conv(output logic timed_out, output int done_gap);
        int cycles;
        int last_result;
        logic seen_done;
        got.delete();
        start = 1'b1;
        step();
        start = 1'b0;
        cycles = 0;
        last_result = 0;
        seen_done = 1'b0;
        while (!seen_done && cycles < RUN_LIMIT) begin
            step();
            cycles++;
            if (result_valid) begin
                got.push_back(result);
                last_result = cycles;
            end
            seen_done = done;
        end
        timed_out = !seen_done;
        done_gap = cycles - last_result;
    endtask

    task automatic report_test(input int id, input int case_errors);
        $display("test %0d finished with %0d errors", id, case_errors);
        errors += case_errors;
        if (case_errors != 0) begin
            failed_tests++;
        end
    endtask

    initial begin
        logic timed_out;
        logic seen;
        int c;
        int k;
        int case_errors;
        int done_gap;
        clk = 1'b0;
        reset = 1'b1;
        ifmap_valid = 1'b0;
        ifmap_in = '0;
        cfg_valid = 1'b0;
        cfg_in = '0;
        filt_valid = 1'b0;
        filt_in = '0;
        start = 1'b0;
        lfsr = 32'h3e7dea44;
        row_len = 0;
        errors = 0;
        failed_tests = 0;
        checks = 0;
        repeat (5) step();
        reset = 1'b0;

        // Nothing loaded yet, so start must be ignored
        case_errors = 0;
        checks += 2;
        if (result_valid !== 1'b0) begin
            $display("CHECK FAILED t=%0t signal result_valid got %b expected 0",
                     $time, result_valid);
            case_errors++;
        end
        if (done !== 1'b0) begin
            $display("CHECK FAILED t=%0t signal done got %b expected 0", $time, done);
            case_errors++;
        end
        start = 1'b1;
        step();
        start = 1'b0;
        seen = 1'b0;
        for (k = 0; k < IDLE_LIMIT; k++) begin
            step();
            seen = seen || result_valid || done;
        end
        checks++;
        if (seen) begin
            $display("start before any loading produced a result or done");
            case_errors++;
        end
        report_test(0, case_errors);

        for (c = 0; c < NUM_CASES; c++) begin
            case_errors = 0;
            if (CASE_TABLE[c].load_row) begin
                load_row(int'(CASE_TABLE[c].row_len), CASE_TABLE[c].max_data);
            end
            load_filter(int'(CASE_TABLE[c].filt_len), int'(CASE_TABLE[c].stride),
                        CASE_TABLE[c].max_data);
            build_expected(int'(CASE_TABLE[c].filt_len), int'(CASE_TABLE[c].stride));
            if (expected.size() != int'(CASE_TABLE[c].exp_windows)) begin
                $display("case %0d window count in the table disagrees with the model",
                         c + 1);
                case_errors++;
            end
            run_conv(timed_out, done_gap);
            if (timed_out) begin
                $display("case %0d saw no done within %0d cycles", c + 1, RUN_LIMIT);
                case_errors++;
            end
            checks++;
            if (got.size() != expected.size()) begin
                $display("CHECK FAILED t=%0t signal result_valid count got %0d expected %0d",
                         $time, got.size(), expected.size());
                case_errors++;
            end
            for (k = 0; k < got.size() && k < expected.size(); k++) begin
                checks++;
                if (got[k] !== expected[k]) begin
                    $display("CHECK FAILED t=%0t signal result window %0d got %0d expected %0d",
                             $time, k, got[k], expected[k]);
                    case_errors++;
                end
            end
            // done comes in the cycle after the final result
            if (!timed_out && got.size() != 0) begin
                checks++;
                if (done_gap != 1) begin
                    $display("CHECK FAILED t=%0t signal done delay got %0d expected 1",
                             $time, done_gap);
                    case_errors++;
                end
            end
            // One cycle wide strobe
            step();
            checks++;
            if (done !== 1'b0) begin
                $display("CHECK FAILED t=%0t signal done got %b expected 0", $time, done);
                case_errors++;
            end
            report_test(c + 1, case_errors);
        end

        $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 NUM_CASES + 1, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: conv_pe.sv
`timescale 1ns/10ps

module conv_pe (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ifmap_valid,
    input  pe_pkg::ifmap_word_t         ifmap_in,
    input  logic                        cfg_valid,
    input  pe_pkg::conv_cfg_t           cfg_in,
    input  logic                        filt_valid,
    input  pe_pkg::filt_word_t          filt_in,
    input  logic                        start,
    output logic                        result_valid,
    output logic [pe_pkg::ACC_W-1:0]    result,
    output logic                        done
);

    // Feature side
    logic                            if_wen;
    logic [pe_pkg::IF_ADDR_W-1:0]    if_waddr;
    pe_pkg::if_data_t                if_wdata;
    pe_pkg::if_data_t                if_rdata;
    logic                            ifmap_ready;
    pe_pkg::if_len_t                 ifmap_len;

    // Filter side
    logic                            filt_wen;
    logic [pe_pkg::FILT_ADDR_W-1:0]  filt_waddr;
    pe_pkg::filt_word_t              filt_wdata;
    pe_pkg::filt_word_t              filt_rdata;
    pe_pkg::conv_cfg_t               cfg;
    logic                            filt_ready;

    // Read side
    logic                            ren;
    logic [pe_pkg::IF_ADDR_W-1:0]    if_raddr;
    logic [pe_pkg::FILT_ADDR_W-1:0]  filt_raddr;
    pe_pkg::mac_ctl_t                ctl;
    logic                            busy;

    ifmap_loader i_ifmap_loader (
        .clk(clk), .reset(reset), .ifmap_valid(ifmap_valid), .ifmap_in(ifmap_in),
        .wen(if_wen), .waddr(if_waddr), .wdata(if_wdata),
        .ifmap_ready(ifmap_ready), .ifmap_len(ifmap_len)
    );

    filter_loader i_filter_loader (
        .clk(clk), .reset(reset), .cfg_valid(cfg_valid), .cfg_in(cfg_in),
        .filt_valid(filt_valid), .filt_in(filt_in),
        .wen(filt_wen), .waddr(filt_waddr), .wdata(filt_wdata),
        .cfg(cfg), .filt_ready(filt_ready)
    );

    pe_scratchpad #(.payload_t(pe_pkg::if_data_t), .DEPTH(pe_pkg::IF_DEPTH)) i_if_spad (
        .clk(clk), .reset(reset), .wen(if_wen), .waddr(if_waddr), .wdata(if_wdata),
        .ren(ren), .raddr(if_raddr), .rdata(if_rdata)
    );

    pe_scratchpad #(.payload_t(pe_pkg::filt_word_t), .DEPTH(pe_pkg::FILT_DEPTH)) i_filt_spad (
        .clk(clk), .reset(reset), .wen(filt_wen), .waddr(filt_waddr), .wdata(filt_wdata),
        .ren(ren), .raddr(filt_raddr), .rdata(filt_rdata)
    );

    window_sequencer i_window_sequencer (
        .clk(clk), .reset(reset), .start(start),
        .ifmap_ready(ifmap_ready), .filt_ready(filt_ready),
        .ifmap_len(ifmap_len), .cfg(cfg),
        .ren(ren), .if_raddr(if_raddr), .filt_raddr(filt_raddr),
        .ctl(ctl), .busy(busy)
    );

    mac_pipeline i_mac_pipeline (
        .clk(clk), .reset(reset), .ctl(ctl),
        .if_data(if_rdata), .filt_data(filt_rdata.data),
        .result_valid(result_valid), .result(result), .done(done)
    );

    // Scratchpads and cfg must stay stable while windows are being read
    a_no_load_while_busy: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !ifmap_valid && !cfg_valid && !filt_valid
    ) else $error("load strobe while the convolution is running");

endmodule

// File: mac_pipeline.sv
`timescale 1ns/10ps

module mac_pipeline (
    input  logic                        clk,
    input  logic                        reset,
    input  pe_pkg::mac_ctl_t            ctl,
    input  logic [pe_pkg::DATA_W-1:0]   if_data,
    input  logic [pe_pkg::DATA_W-1:0]   filt_data,
    output logic                        result_valid,
    output logic [pe_pkg::ACC_W-1:0]    result,
    output logic                        done
);

    pe_pkg::mac_ctl_t               ctl_s1;
    pe_pkg::mac_ctl_t               ctl_s2;
    logic [pe_pkg::DATA_W-1:0]      if_s1;
    logic [pe_pkg::DATA_W-1:0]      filt_s1;
    logic [pe_pkg::PROD_W-1:0]      prod_s2;
    logic [pe_pkg::ACC_W-1:0]       prod_ext;
    logic [pe_pkg::ACC_W-1:0]       acc;
    logic                           final_s3;

    // Control travels alongside the data
    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_s1       <= '0;
            ctl_s2       <= '0;
            result_valid <= 1'b0;
            final_s3     <= 1'b0;
            done         <= 1'b0;
        end else begin
            ctl_s1       <= ctl;
            ctl_s2       <= ctl_s1;
            result_valid <= ctl_s2.valid && ctl_s2.last;
            final_s3     <= ctl_s2.final_win;
            // One cycle after the last result
            done         <= final_s3;
        end
    end

    // Stage 1 operands
    always_ff @(posedge clk) begin
        if (ctl.valid) begin
            if_s1   <= if_data;
            filt_s1 <= filt_data;
        end
    end

    // Stage 2 product
    always_ff @(posedge clk) begin
        if (ctl_s1.valid) begin
            prod_s2 <= if_s1 * filt_s1;
        end
    end

    assign prod_ext = {{(pe_pkg::ACC_W - pe_pkg::PROD_W){1'b0}}, prod_s2};

    // Stage 3 accumulate, restart on the first tap of each window
    always_ff @(posedge clk) begin
        if (ctl_s2.valid) begin
            if (ctl_s2.first) begin
                acc <= prod_ext;
            end else begin
                acc <= acc + prod_ext;
            end
        end
    end

    assign result = acc;

endmodule

// File: window_sequencer.sv
`timescale 1ns/10ps

module window_sequencer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            ifmap_ready,
    input  logic                            filt_ready,
    input  pe_pkg::if_len_t                 ifmap_len,
    input  pe_pkg::conv_cfg_t               cfg,
    output logic                            ren,
    output logic [pe_pkg::IF_ADDR_W-1:0]    if_raddr,
    output logic [pe_pkg::FILT_ADDR_W-1:0]  filt_raddr,
    output pe_pkg::mac_ctl_t                ctl,
    output logic                            busy
);

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_t;

    state_t                          state;
    logic [pe_pkg::IF_ADDR_W-1:0]    base;
    logic [pe_pkg::FILT_ADDR_W-1:0]  tap;
    pe_pkg::if_len_t                 win_left;

    pe_pkg::if_len_t   flen_ext;
    pe_pkg::if_len_t   stride_ext;
    pe_pkg::if_len_t   span;
    pe_pkg::if_len_t   num_win;
    logic              start_ok;
    logic              last_tap;
    logic              last_win;
    pe_pkg::mac_ctl_t  ctl_next;

    // Window count, floor((len - F) / stride) + 1, zero if the filter does not fit
    assign flen_ext   = {{(pe_pkg::IF_ADDR_W - pe_pkg::FILT_ADDR_W){1'b0}}, cfg.filt_len};
    assign stride_ext = {1'b0, cfg.stride};
    assign span       = ifmap_len - flen_ext;
    assign num_win    = (ifmap_len < flen_ext) ? '0 : (span / stride_ext) + 1'b1;

    assign start_ok = start && (state == S_IDLE) && ifmap_ready && filt_ready;
    assign last_tap = ({1'b0, tap} + 1'b1) == cfg.filt_len;
    assign last_win = win_left == pe_pkg::if_len_t'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            base     <= '0;
            tap      <= '0;
            win_left <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_ok && (num_win != '0)) begin
                        state    <= S_RUN;
                        base     <= '0;
                        tap      <= '0;
                        win_left <= num_win;
                    end
                end
                S_RUN: begin
                    if (last_tap) begin
                        // Next window starts one stride further along
                        tap      <= '0;
                        base     <= base + cfg.stride;
                        win_left <= win_left - 1'b1;
                        if (last_win) begin
                            state <= S_IDLE;
                        end
                    end else begin
                        tap <= tap + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign busy       = state == S_RUN;
    assign ren        = busy;
    assign if_raddr   = base + {{(pe_pkg::IF_ADDR_W - pe_pkg::FILT_ADDR_W){1'b0}}, tap};
    assign filt_raddr = tap;

    // An empty run still sends a final mark so done is produced
    always_comb begin
        ctl_next.valid     = ren;
        ctl_next.first     = ren && (tap == '0);
        ctl_next.last      = ren && last_tap;
        ctl_next.final_win = (ren && last_tap && last_win) || (start_ok && (num_win == '0));
    end

    // Lines up with the scratchpad read data
    always_ff @(posedge clk) begin
        if (reset) begin
            ctl <= '0;
        end else begin
            ctl <= ctl_next;
        end
    end

    a_read_in_row: assert property (
        @(posedge clk) disable iff (reset)
        ren |-> ({1'b0, if_raddr} < ifmap_len)
    ) else $error("feature read address %0d beyond row length %0d", if_raddr, ifmap_len);

endmodule

// File: filter_loader.sv
`timescale 1ns/10ps

module filter_loader (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cfg_valid,
    input  pe_pkg::conv_cfg_t               cfg_in,
    input  logic                            filt_valid,
    input  pe_pkg::filt_word_t              filt_in,
    output logic                            wen,
    output logic [pe_pkg::FILT_ADDR_W-1:0]  waddr,
    output pe_pkg::filt_word_t              wdata,
    output pe_pkg::conv_cfg_t               cfg,
    output logic                            filt_ready
);

    // Filter words accepted since the last cfg strobe
    pe_pkg::filt_len_t count;

    // Words beyond the filter length are dropped
    assign wen   = filt_valid && !cfg_valid && (count < cfg.filt_len);
    assign waddr = count[pe_pkg::FILT_ADDR_W-1:0];
    assign wdata = filt_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg        <= '0;
            count      <= '0;
            filt_ready <= 1'b0;
        end else if (cfg_valid) begin
            cfg        <= cfg_in;
            count      <= '0;
            filt_ready <= 1'b0;
        end else if (wen) begin
            count <= count + 1'b1;
            if (count + 1'b1 == cfg.filt_len) begin
                filt_ready <= 1'b1;
            end
        end
    end

    a_cfg_legal: assert property (
        @(posedge clk) disable iff (reset)
        cfg_valid |-> (cfg_in.filt_len >= 1)
                   && (int'(cfg_in.filt_len) <= pe_pkg::FILT_DEPTH)
                   && (cfg_in.stride != '0)
    ) else $error("illegal cfg, filt_len %0d stride %0d",
                  cfg_in.filt_len, cfg_in.stride);

endmodule

// File: ifmap_loader.sv
`timescale 1ns/10ps

module ifmap_loader (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ifmap_valid,
    input  pe_pkg::ifmap_word_t            ifmap_in,
    output logic                           wen,
    output logic [pe_pkg::IF_ADDR_W-1:0]   waddr,
    output pe_pkg::if_data_t               wdata,
    output logic                           ifmap_ready,
    output pe_pkg::if_len_t                ifmap_len
);

    // Words written so far in the current row
    pe_pkg::if_len_t count;

    // Every strobed word goes straight into the scratchpad
    assign wen   = ifmap_valid;
    assign waddr = count[pe_pkg::IF_ADDR_W-1:0];
    assign wdata = ifmap_in.data;

    always_ff @(posedge clk) begin
        if (reset) begin
            count       <= '0;
            ifmap_len   <= '0;
            ifmap_ready <= 1'b0;
        end else if (ifmap_valid) begin
            if (ifmap_in.last) begin
                // Row complete, restart for the next row
                count       <= '0;
                ifmap_len   <= count + 1'b1;
                ifmap_ready <= 1'b1;
            end else begin
                count <= count + 1'b1;
                // First word of a new row invalidates the old one
                if (count == '0) begin
                    ifmap_ready <= 1'b0;
                end
            end
        end
    end

    // The word in the last entry has to close the row
    a_row_fits: assert property (
        @(posedge clk) disable iff (reset)
        (ifmap_valid && (count == pe_pkg::if_len_t'(pe_pkg::IF_DEPTH - 1)))
            |-> ifmap_in.last
    ) else $error("feature row longer than %0d words", pe_pkg::IF_DEPTH);

endmodule

// File: pe_scratchpad.sv
`timescale 1ns/10ps

module pe_scratchpad #(
    parameter type payload_t = pe_pkg::filt_word_t,
    parameter int  DEPTH     = pe_pkg::FILT_DEPTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic                     ren,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, holds the last word while idle
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

    // Only matters for a depth that is not a power of two
    a_waddr_range: assert property (
        @(posedge clk) disable iff (reset)
        wen |-> (int'(waddr) < DEPTH)
    ) else $error("scratchpad write address %0d out of range", waddr);

endmodule

// File: pe_pkg.sv
package pe_pkg;

    // Feature and filter word width
    localparam int DATA_W = 8;

    // Feature row scratchpad
    localparam int IF_DEPTH  = 32;
    localparam int IF_ADDR_W = 5;

    // Filter row scratchpad
    localparam int FILT_DEPTH  = 8;
    localparam int FILT_ADDR_W = 3;

    // Product and accumulator widths
    // 3 guard bits cover the sum of FILT_DEPTH products
    localparam int PROD_W = 2 * DATA_W;
    localparam int ACC_W  = PROD_W + 3;

    // Row length as a count, 0 to IF_DEPTH
    typedef logic [IF_ADDR_W:0] if_len_t;

    // Filter length as a count, 1 to FILT_DEPTH
    typedef logic [FILT_ADDR_W:0] filt_len_t;

    // Feature value as stored in the scratchpad
    typedef logic [DATA_W-1:0] if_data_t;

    // Incoming feature word, last marks the end of the row
    typedef struct packed {
        logic     last;
        if_data_t data;
    } ifmap_word_t;

    // Incoming filter word
    typedef struct packed {
        logic [DATA_W-1:0] data;
    } filt_word_t;

    // Convolution setup
    typedef struct packed {
        filt_len_t            filt_len;
        logic [IF_ADDR_W-1:0] stride;
    } conv_cfg_t;

    // Per-read control towards the MAC pipeline
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
        logic final_win;   // last read of the run, or an empty run
    } mac_ctl_t;

endpackage
